//--- hdl/trace_cfg.svh
// Trace funnel sizes and APB register offsets

`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

`define TRACE_NUM_CORES        8
`define TRACE_CORES_PER_BRANCH 4
`define TRACE_DATA_W           32
`define TRACE_RAM_DEPTH        64
`define TRACE_PTR_W            6
`define TRACE_APB_ADDR_W       12
`define TRACE_DATA_RD_WAIT     3

// Register map
`define REG_CONTROL  12'h000
`define REG_DISINPUT 12'h004
`define REG_VIDMAP   12'h008
`define REG_WP       12'h00C
`define REG_RP       12'h010
`define REG_DATA     12'h014
`define REG_NUMSRCS  12'h018

`endif

//--- hdl/tracePkg.sv
// Shared types of the trace funnel
// Core vectors, ids, pointers, APB words and the readout state

`include "trace_cfg.svh"

package tracePkg;

  typedef logic [`TRACE_NUM_CORES-1:0]          coreVec_t;
  typedef logic [$clog2(`TRACE_NUM_CORES)-1:0]  coreId_t;
  typedef coreId_t [`TRACE_NUM_CORES-1:0]       vidMap_t;
  typedef logic [`TRACE_DATA_W-1:0]             traceWord_t;
  typedef logic [`TRACE_PTR_W-1:0]              ramPtr_t;
  typedef logic [$clog2(`TRACE_NUM_CORES):0]    srcCount_t;
  typedef logic [`TRACE_APB_ADDR_W-1:0]         apbAddr_t;
  typedef logic [31:0]                          apbData_t;

  // DATA register readout sequence
  typedef enum logic [1:0] {
    RdIdle,
    RdAccess,
    RdWait,
    RdDone
  } rdState_e;

endpackage

//--- hdl/funnelRegs.sv
// APB register block of the trace funnel
// Control, disable and map registers plus the DATA readout sequencer

`timescale 1ns/1ns
`include "trace_cfg.svh"

module funnelRegs
  import tracePkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       psel_i,
  input  logic       penable_i,
  input  logic       pwrite_i,
  input  apbAddr_t   paddr_i,
  input  apbData_t   pwdata_i,
  input  srcCount_t  numSrcs_i,
  input  ramPtr_t    wp_i,
  input  logic       wrapped_i,
  input  logic       full_i,
  input  traceWord_t ramData_i,
  output apbData_t   prdata_o,
  output logic       pready_o,
  output logic       pslverr_o,
  output logic       active_o,
  output logic       wrap_o,
  output coreVec_t   fuseEn_o,
  output coreVec_t   disInput_o,
  output vidMap_t    vidMap_o,
  output logic       wpClear_o,
  output logic       rpLoad_o,
  output ramPtr_t    rpValue_o,
  output logic       rdPop_o
);

  rdState_e rdState;
  rdState_e rdNext;
  ramPtr_t  rdPtr;
  logic     accessPhase;
  logic     isData;
  logic     dataRead;
  logic     addrHit;
  logic     roWrite;
  logic     regWr;

  assign accessPhase = psel_i & penable_i;
  assign isData      = paddr_i == `REG_DATA;
  assign dataRead    = accessPhase & ~pwrite_i & isData;
  assign addrHit     = (paddr_i == `REG_CONTROL) | (paddr_i == `REG_DISINPUT) |
                       (paddr_i == `REG_VIDMAP) | (paddr_i == `REG_WP) |
                       (paddr_i == `REG_RP) | isData | (paddr_i == `REG_NUMSRCS);
  assign roWrite     = pwrite_i & (isData | (paddr_i == `REG_NUMSRCS));

  // DATA reads finish on the third access cycle, everything else on the first
  assign pready_o  = dataRead ? (rdState == RdDone) : accessPhase;
  assign pslverr_o = pready_o & (~addrHit | roWrite);
  assign regWr     = pready_o & pwrite_i & ~pslverr_o;

  assign wpClear_o = regWr & (paddr_i == `REG_WP);
  assign rpLoad_o  = regWr & (paddr_i == `REG_RP);
  assign rpValue_o = pwdata_i[$bits(ramPtr_t)-1:0];
  assign rdPop_o   = dataRead & (rdState == RdAccess);

  // --------------------------------------------------------------------
  // Readout sequencer
  // --------------------------------------------------------------------
  always_comb begin
    rdNext = rdState;
    case (rdState)
      RdIdle:   if (psel_i & ~penable_i & ~pwrite_i & isData) rdNext = RdAccess;
      RdAccess: rdNext = RdWait;
      RdWait:   rdNext = RdDone;
      RdDone:   rdNext = RdIdle;
      default:  rdNext = RdIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdState <= RdIdle;
      rdPtr   <= '0;
    end else begin
      rdState <= rdNext;
      // Shadow of the RAM read pointer for readback
      if (rpLoad_o) rdPtr <= rpValue_o;
      else if (rdPop_o) rdPtr <= rdPtr + ramPtr_t'(1);
    end
  end

  // --------------------------------------------------------------------
  // Control registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_o   <= 1'b0;
      wrap_o     <= 1'b0;
      fuseEn_o   <= '0;
      disInput_o <= '0;
      vidMap_o   <= '0;
    end else if (regWr) begin
      case (paddr_i)
        `REG_CONTROL: begin
          active_o <= pwdata_i[0];
          wrap_o   <= pwdata_i[1];
          fuseEn_o <= pwdata_i[15:8];
        end
        `REG_DISINPUT: disInput_o <= pwdata_i[7:0];
        `REG_VIDMAP:   vidMap_o   <= vidMap_t'(pwdata_i[$bits(vidMap_t)-1:0]);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (paddr_i)
      `REG_CONTROL:  prdata_o = apbData_t'({fuseEn_o, 6'b0, wrap_o, active_o});
      `REG_DISINPUT: prdata_o = apbData_t'(disInput_o);
      `REG_VIDMAP:   prdata_o = apbData_t'(vidMap_o);
      `REG_WP:       prdata_o = apbData_t'({full_i, wrapped_i, 2'b0, wp_i});
      `REG_RP:       prdata_o = apbData_t'(rdPtr);
      `REG_DATA:     prdata_o = apbData_t'(ramData_i);
      `REG_NUMSRCS:  prdata_o = apbData_t'(numSrcs_i);
      default:       prdata_o = '0;
    endcase
  end

  readyInAccess: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(pready_o) |-> psel_i && penable_i);

endmodule

//--- hdl/harvestMap.sv
// Core harvesting map
// Physical enable vector from fuses, virtual ids and disables, plus its count

`timescale 1ns/1ns

module harvestMap
  import tracePkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      active_i,
  input  coreVec_t  fuseEn_i,
  input  coreVec_t  disInput_i,
  input  vidMap_t   vidMap_i,
  output coreVec_t  enabledSrcs_o,
  output srcCount_t numSrcs_o
);

  coreVec_t  enNext;
  srcCount_t cntNext;

  // A physical core is live when fused in and its virtual id is not disabled
  always_comb begin
    enNext  = '0;
    cntNext = '0;
    for (int p = 0; p < $bits(coreVec_t); p++) begin
      enNext[p] = active_i & fuseEn_i[p] & ~disInput_i[vidMap_i[p]];
      cntNext   = cntNext + srcCount_t'(enNext[p]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enabledSrcs_o <= '0;
      numSrcs_o     <= '0;
    end else begin
      enabledSrcs_o <= enNext;
      numSrcs_o     <= cntNext;
    end
  end

  countMatchesVector: assert property (@(posedge clk_i) disable iff (reset_i)
    numSrcs_o == srcCount_t'($countones(enabledSrcs_o)));

endmodule

//--- hdl/branchMerge.sv
// First funnel stage
// Filters branch valids by the enable vector and merges north before south

`timescale 1ns/1ns
`include "trace_cfg.svh"

module branchMerge
  import tracePkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic [`TRACE_CORES_PER_BRANCH-1:0]  northVld_i,
  input  logic [`TRACE_CORES_PER_BRANCH-1:0]  southVld_i,
  input  traceWord_t                          northData_i,
  input  traceWord_t                          southData_i,
  input  coreVec_t                            enabledSrcs_i,
  input  logic                                ramStop_i,
  output logic                                wrVld_o,
  output traceWord_t                          wrData_o,
  output logic                                traceBp_o
);

  localparam int unsigned Cpb = `TRACE_CORES_PER_BRANCH;

  logic       northHit;
  logic       southHit;
  logic       slotVld;
  traceWord_t slotData;

  // North is branch 0, so it owns the low half of the enables
  assign northHit  = (|(northVld_i & enabledSrcs_i[Cpb-1:0])) & ~ramStop_i;
  assign southHit  = (|(southVld_i & enabledSrcs_i[2*Cpb-1:Cpb])) & ~ramStop_i;
  assign traceBp_o = slotVld | ramStop_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wrVld_o <= 1'b0;
      slotVld <= 1'b0;
    end else begin
      wrVld_o <= slotVld | northHit | southHit;
      // South waits one cycle when both branches fire together
      slotVld <= ~slotVld & northHit & southHit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slotVld) begin
      wrData_o <= slotData;
    end else if (northHit) begin
      wrData_o <= northData_i;
    end else if (southHit) begin
      wrData_o <= southData_i;
    end
    if (northHit & southHit) begin
      slotData <= southData_i;
    end
  end

  noValidUnderBp: assert property (@(posedge clk_i) disable iff (reset_i)
    traceBp_o |-> !(|northVld_i) && !(|southVld_i));

endmodule

//--- hdl/traceRamWriter.sv
// Second funnel stage
// Trace RAM with stop or wrap write pointer and auto-incrementing read port

`timescale 1ns/1ns
`include "trace_cfg.svh"

module traceRamWriter
  import tracePkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       wrVld_i,
  input  traceWord_t wrData_i,
  input  logic       active_i,
  input  logic       wrap_i,
  input  logic       wpClear_i,
  input  logic       rpLoad_i,
  input  ramPtr_t    rpValue_i,
  input  logic       rdPop_i,
  output ramPtr_t    wp_o,
  output logic       wrapped_o,
  output logic       full_o,
  output logic       ramStop_o,
  output traceWord_t ramData_o
);

  localparam ramPtr_t LastEntry = ramPtr_t'(`TRACE_RAM_DEPTH - 1);

  traceWord_t ram [`TRACE_RAM_DEPTH];
  ramPtr_t    rdPtr;
  logic       wrEn;
  logic       atLast;

  assign wrEn   = wrVld_i & active_i & ~full_o;
  assign atLast = wp_o == LastEntry;

  // Stop the merge stage one word early so nothing new lands on a full RAM
  assign ramStop_o = full_o | (wrEn & atLast & ~wrap_i);

  // --------------------------------------------------------------------
  // Write pointer
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wp_o      <= '0;
      wrapped_o <= 1'b0;
      full_o    <= 1'b0;
    end else if (wpClear_i) begin
      wp_o      <= '0;
      wrapped_o <= 1'b0;
      full_o    <= 1'b0;
    end else if (wrEn) begin
      wp_o <= wp_o + ramPtr_t'(1);
      if (atLast) begin
        wrapped_o <= wrapped_o | wrap_i;
        full_o    <= ~wrap_i;
      end
    end
  end

  // Read pointer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdPtr <= '0;
    end else if (rpLoad_i) begin
      rdPtr <= rpValue_i;
    end else if (rdPop_i) begin
      rdPtr <= rdPtr + ramPtr_t'(1);
    end
  end

  // --------------------------------------------------------------------
  // Storage and read holding register
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wrEn) begin
      ram[wp_o] <= wrData_i;
    end
    if (rdPop_i) begin
      ramData_o <= ram[rdPtr];
    end
  end

endmodule

//--- hdl/traceFunnel.sv
// Trace funnel top level
// APB register block, harvest map and the merge and RAM write stages

`timescale 1ns/1ns
`include "trace_cfg.svh"

module traceFunnel
  import tracePkg::*;
(
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  apbAddr_t                            paddr_i,
  input  apbData_t                            pwdata_i,
  output apbData_t                            prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  input  logic [`TRACE_CORES_PER_BRANCH-1:0]  northVld_i,
  input  traceWord_t                          northData_i,
  input  logic [`TRACE_CORES_PER_BRANCH-1:0]  southVld_i,
  input  traceWord_t                          southData_i,
  output logic                                traceBp_o,
  output coreVec_t                            enabledSrcs_o
);

  logic       active;
  logic       wrap;
  coreVec_t   fuseEn;
  coreVec_t   disInput;
  vidMap_t    vidMap;
  srcCount_t  numSrcs;
  logic       wpClear;
  logic       rpLoad;
  ramPtr_t    rpValue;
  logic       rdPop;
  ramPtr_t    wp;
  logic       wrapped;
  logic       full;
  logic       ramStop;
  traceWord_t ramData;
  logic       wrVld;
  traceWord_t wrData;

  funnelRegs u_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .numSrcs_i  (numSrcs),
    .wp_i       (wp),
    .wrapped_i  (wrapped),
    .full_i     (full),
    .ramData_i  (ramData),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .active_o   (active),
    .wrap_o     (wrap),
    .fuseEn_o   (fuseEn),
    .disInput_o (disInput),
    .vidMap_o   (vidMap),
    .wpClear_o  (wpClear),
    .rpLoad_o   (rpLoad),
    .rpValue_o  (rpValue),
    .rdPop_o    (rdPop)
  );

  harvestMap u_harvest (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .active_i      (active),
    .fuseEn_i      (fuseEn),
    .disInput_i    (disInput),
    .vidMap_i      (vidMap),
    .enabledSrcs_o (enabledSrcs_o),
    .numSrcs_o     (numSrcs)
  );

  branchMerge u_merge (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .northVld_i    (northVld_i),
    .southVld_i    (southVld_i),
    .northData_i   (northData_i),
    .southData_i   (southData_i),
    .enabledSrcs_i (enabledSrcs_o),
    .ramStop_i     (ramStop),
    .wrVld_o       (wrVld),
    .wrData_o      (wrData),
    .traceBp_o     (traceBp_o)
  );

  traceRamWriter u_ramWriter (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wrVld_i   (wrVld),
    .wrData_i  (wrData),
    .active_i  (active),
    .wrap_i    (wrap),
    .wpClear_i (wpClear),
    .rpLoad_i  (rpLoad),
    .rpValue_i (rpValue),
    .rdPop_i   (rdPop),
    .wp_o      (wp),
    .wrapped_o (wrapped),
    .full_o    (full),
    .ramStop_o (ramStop),
    .ramData_o (ramData)
  );

endmodule

//--- bench/tbTraceModel.svh
// Reference model of the trace funnel
// Register mirror, harvest rule, merge order and trace RAM contents

`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

typedef logic [`TRACE_CORES_PER_BRANCH-1:0] branchVld_t;

// Mirror of the programmed registers
logic       regActive = 1'b0;
logic       regWrap   = 1'b0;
coreVec_t   regFuse   = '0;
coreVec_t   regDis    = '0;
vidMap_t    regMap    = '0;

traceWord_t modelRam [`TRACE_RAM_DEPTH];
ramPtr_t    modelWp      = '0;
logic       modelWrapped = 1'b0;
logic       modelFull    = 1'b0;
int         modelPushed  = 0;

// Live when active, fused in and the virtual id is not disabled
function automatic coreVec_t modelEnables();
  coreVec_t en;
  en = '0;
  for (int p = 0; p < `TRACE_NUM_CORES; p++) begin
    if (regActive && regFuse[p] && !regDis[regMap[p]]) begin
      en[p] = 1'b1;
    end
  end
  return en;
endfunction

function automatic srcCount_t modelCount(input coreVec_t v);
  srcCount_t n;
  n = '0;
  for (int i = 0; i < `TRACE_NUM_CORES; i++) begin
    if (v[i]) begin
      n = n + srcCount_t'(1);
    end
  end
  return n;
endfunction

task automatic modelClearWp();
  modelWp      = '0;
  modelWrapped = 1'b0;
  modelFull    = 1'b0;
endtask

// Stop mode freezes at full, wrap mode starts over at entry 0
task automatic modelPush(input traceWord_t w);
  modelPushed++;
  if (!modelFull) begin
    modelRam[modelWp] = w;
    if (modelWp == ramPtr_t'(`TRACE_RAM_DEPTH - 1)) begin
      if (regWrap) begin
        modelWrapped = 1'b1;
      end else begin
        modelFull = 1'b1;
      end
    end
    modelWp = modelWp + ramPtr_t'(1);
  end
endtask

// North lands first when both branches deliver together
task automatic modelMerge(input branchVld_t nVld, input branchVld_t sVld,
                          input traceWord_t nData, input traceWord_t sData);
  coreVec_t en;
  en = modelEnables();
  if ((nVld & en[3:0]) != '0) begin
    modelPush(nData);
  end
  if ((sVld & en[7:4]) != '0) begin
    modelPush(sData);
  end
endtask

`endif

//--- bench/tbTraceFunnel.sv
// Trace funnel testbench
// Clock, reset, LCG stimulus, APB access, compare tasks and watchdog

`timescale 1ns/1ns
`include "trace_cfg.svh"

module tbTraceFunnel
  import tracePkg::*;
();

  `include "tbTraceModel.svh"

  // Tests take roughly 2500 cycles
  localparam int TimeoutCycles = 20000;

  logic        clk_i;
  logic        reset_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  apbAddr_t    paddr_i;
  apbData_t    pwdata_i;
  apbData_t    prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  branchVld_t  northVld_i;
  traceWord_t  northData_i;
  branchVld_t  southVld_i;
  traceWord_t  southData_i;
  logic        traceBp_o;
  coreVec_t    enabledSrcs_o;
  logic [31:0] lcgState = 32'd12414;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  traceFunnel u_traceFunnel (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic checkVec(input string name, input coreVec_t got, input coreVec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input srcCount_t got, input srcCount_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkWord(input string name, input traceWord_t got, input traceWord_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkPtr(input string name, input ramPtr_t got, input ramPtr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Upper half of the LCG state since its low bits repeat quickly
  function automatic logic [15:0] randBits();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];
  endfunction

  // One-hot valid that stays idle about a quarter of the time
  function automatic branchVld_t randVld();
    logic [15:0] r;
    r = randBits();
    if (r[1:0] == 2'd0) begin
      return '0;
    end
    return branchVld_t'(1) << r[3:2];
  endfunction

  // ----------------------------------------------------------------------
  // APB access
  // ----------------------------------------------------------------------
  task automatic apbAccess(input logic write, input apbAddr_t addr, input apbData_t wdata,
                           output apbData_t rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(posedge clk_i);
    while (!pready_o && waits < 8) begin
      waits++;
      @(posedge clk_i);
    end
    if (!pready_o) begin
      errors++;
      $display("APB transfer to address 0x%0h never got pready", addr);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apbWrite(input apbAddr_t addr, input apbData_t data);
    apbData_t rd;
    logic     err;
    apbAccess(1'b1, addr, data, rd, err);
    checkFlag("pslverr_o", err, 1'b0);
  endtask

  task automatic apbRead(input apbAddr_t addr, output apbData_t data);
    logic err;
    apbAccess(1'b0, addr, '0, data, err);
    checkFlag("pslverr_o", err, 1'b0);
  endtask

  task automatic programRegs(input logic ctlActive, input logic ctlWrap, input coreVec_t fuse,
                             input coreVec_t dis, input vidMap_t map);
    apbWrite(`REG_CONTROL, {16'h0, fuse, 6'h0, ctlWrap, ctlActive});
    apbWrite(`REG_DISINPUT, apbData_t'(dis));
    apbWrite(`REG_VIDMAP, apbData_t'(map));
    regActive = ctlActive;
    regWrap   = ctlWrap;
    regFuse   = fuse;
    regDis    = dis;
    regMap    = map;
    // Harvest map registers one edge after the last write
    @(negedge clk_i);
  endtask

  task automatic clearWp();
    apbWrite(`REG_WP, '0);
    modelClearWp();
  endtask

  task automatic checkWpReg(output apbData_t rd);
    apbRead(`REG_WP, rd);
    checkPtr("REG_WP.ptr", rd[5:0], modelWp);
    checkFlag("REG_WP.wrapped", rd[8], modelWrapped);
    checkFlag("REG_WP.full", rd[9], modelFull);
  endtask

  task automatic readEntries(input int start, input int count);
    apbData_t rd;
    apbWrite(`REG_RP, apbData_t'(start));
    for (int i = 0; i < count; i++) begin
      apbRead(`REG_DATA, rd);
      checkWord("REG_DATA", rd, modelRam[ramPtr_t'(start + i)]);
    end
  endtask

  // Drives words until the model has taken the given number from live sources
  task automatic runTraffic(input int words);
    branchVld_t nVld;
    branchVld_t sVld;
    traceWord_t nData;
    traceWord_t sData;
    coreVec_t   en;
    int         target;
    target = modelPushed + words;
    while (modelPushed < target) begin
      @(negedge clk_i);
      en    = modelEnables();
      nVld  = '0;
      sVld  = '0;
      nData = {randBits(), randBits()};
      sData = {randBits(), randBits()};
      if (!traceBp_o) begin
        nVld = randVld();
        sVld = randVld();
      end
      // Last word of the budget comes from one branch
      if (target - modelPushed == 1 && (nVld & en[3:0]) != '0) begin
        sVld = '0;
      end
      northVld_i  = nVld;
      southVld_i  = sVld;
      northData_i = nData;
      southData_i = sData;
      modelMerge(nVld, sVld, nData, sData);
    end
    @(negedge clk_i);
    northVld_i = '0;
    southVld_i = '0;
    // Merge and RAM write stages drain
    repeat (2) @(negedge clk_i);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    apbData_t    rd;
    logic        err;
    logic [31:0] raw;
    vidMap_t     map;
    reset_i     = 1'b1;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    northVld_i  = '0;
    southVld_i  = '0;
    northData_i = '0;
    southData_i = '0;
    map         = '0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    checkVec("enabledSrcs_o", enabledSrcs_o, '0);
    checkFlag("traceBp_o", traceBp_o, 1'b0);
    checkFlag("pready_o", pready_o, 1'b0);
    checkFlag("pslverr_o", pslverr_o, 1'b0);

    // Harvest programming
    for (int i = 0; i < 20; i++) begin
      raw = {randBits(), randBits()};
      map = {randBits(), raw[23:16]};
      programRegs(raw[31:29] != 3'd0, 1'b0, raw[7:0], raw[15:8], map);
      checkVec("enabledSrcs_o", enabledSrcs_o, modelEnables());
      apbRead(`REG_NUMSRCS, rd);
      checkCount("REG_NUMSRCS", srcCount_t'(rd), modelCount(modelEnables()));
    end

    // Random traffic with one live source kept per branch
    for (int round = 0; round < 3; round++) begin
      raw = {randBits(), randBits()};
      map = {randBits(), raw[23:16]};
      raw[15:8] = raw[15:8] & ~(8'd1 << map[0]) & ~(8'd1 << map[4]);
      programRegs(1'b1, 1'b0, raw[7:0] | 8'h11, raw[15:8], map);
      clearWp();
      runTraffic(30);
      checkWpReg(rd);
      readEntries(0, 30);
    end

    // Stop mode
    programRegs(1'b1, 1'b0, 8'hFF, 8'h00, map);
    clearWp();
    runTraffic(64);
    checkWpReg(rd);
    checkFlag("REG_WP.full", rd[9], 1'b1);
    checkFlag("traceBp_o", traceBp_o, 1'b1);
    readEntries(0, 64);

    // Wrap mode
    programRegs(1'b1, 1'b1, 8'hFF, 8'h00, map);
    clearWp();
    runTraffic(70);
    checkWpReg(rd);
    checkPtr("REG_WP.ptr", rd[5:0], ramPtr_t'(6));
    checkFlag("REG_WP.wrapped", rd[8], 1'b1);
    readEntries(0, 64);

    // APB errors leave the registers alone
    apbAccess(1'b1, `REG_DATA, 32'h0000_3C3C, rd, err);
    checkFlag("pslverr_o", err, 1'b1);
    apbAccess(1'b1, `REG_NUMSRCS, 32'h0000_3C3C, rd, err);
    checkFlag("pslverr_o", err, 1'b1);
    apbAccess(1'b0, 12'h020, '0, rd, err);
    checkFlag("pslverr_o", err, 1'b1);
    apbAccess(1'b1, 12'h040, 32'h0000_3C3C, rd, err);
    checkFlag("pslverr_o", err, 1'b1);
    apbRead(`REG_CONTROL, rd);
    checkVec("REG_CONTROL.fuseEn", rd[15:8], regFuse);
    checkFlag("REG_CONTROL.wrap", rd[1], regWrap);
    checkFlag("REG_CONTROL.active", rd[0], regActive);
    apbRead(`REG_DISINPUT, rd);
    checkVec("REG_DISINPUT", rd[7:0], regDis);
    checkWpReg(rd);
    readEntries(10, 5);
    apbRead(`REG_RP, rd);
    checkPtr("REG_RP", rd[5:0], ramPtr_t'(15));

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+hdl
+incdir+bench
hdl/tracePkg.sv
hdl/funnelRegs.sv
hdl/harvestMap.sv
hdl/branchMerge.sv
hdl/traceRamWriter.sv
hdl/traceFunnel.sv
bench/tbTraceFunnel.sv

//--- Makefile
TOP := tbTraceFunnel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
